// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary -Wno-fatal --top-module dispatch_tb -f verilog.f -o dispatch_sim
	./obj_dir/dispatch_sim | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TESTS PASSED" $(LOG) || (echo "no result in $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: src/dispatch.sv
`timescale 1ns/1ps
`default_nettype none

`include "ooo_consts.svh"

module dispatch (
    input  ooo_pkg::disp_cnt_t                             rob_open,
    input  ooo_pkg::disp_cnt_t                             rs_open,
    input  logic                                           bs_full,
    input  ooo_pkg::decoded_packet_t [`DISPATCH_WIDTH-1:0] decoded,
    output ooo_pkg::disp_cnt_t                             num_dispatch,
    output ooo_pkg::decoded_packet_t [`DISPATCH_WIDTH-1:0] out_insts
);

    import ooo_pkg::*;

    disp_cnt_t num_valid;
    disp_cnt_t num_rob_rs;
    disp_cnt_t limit;

    // valid head entries
    always_comb begin
        num_valid = '0;
        for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
            if (decoded[i].valid) begin
                num_valid = num_valid + 1'b1;
            end
        end
    end

    // least of valid, rob space, rs space
    assign num_rob_rs = (rob_open < rs_open) ? rob_open : rs_open;
    assign limit      = (num_valid < num_rob_rs) ? num_valid : num_rob_rs;

    // in-order scan below the limit
    always_comb begin
        logic stop;
        logic is_br;
        stop         = 1'b0;
        is_br        = 1'b0;
        num_dispatch = '0;
        out_insts    = '0;
        for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
            is_br = decoded[i].cond_branch || decoded[i].uncond_branch;
            if (!stop && decoded[i].valid && (i < limit)) begin
                if (is_br) begin
                    // branch leads only from slot 0 with a free stack entry
                    if (i == 0 && !bs_full) begin
                        out_insts[i] = decoded[i];
                        num_dispatch = num_dispatch + 1'b1;
                    end else begin
                        stop = 1'b1;
                    end
                end else begin
                    out_insts[i] = decoded[i];
                    num_dispatch = num_dispatch + 1'b1;
                end
            end else begin
                // keep the group contiguous
                stop = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/dispatch_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "ooo_consts.svh"

module dispatch_top (
    input  logic                                           clock,
    input  logic                                           arst_n,
    input  logic                                           fetch_valid,
    input  ooo_pkg::disp_cnt_t                             fetch_count,
    input  ooo_pkg::addr_t                                 fetch_pc,
    input  ooo_pkg::inst_t          [`DISPATCH_WIDTH-1:0]  fetch_insts,
    output logic                                           fetch_room,
    input  ooo_pkg::release_t                              releases,
    output ooo_pkg::disp_cnt_t                             num_dispatch,
    output ooo_pkg::decoded_packet_t [`DISPATCH_WIDTH-1:0] out_insts
);

    import ooo_pkg::*;

    inst_packet_t    [`DISPATCH_WIDTH-1:0] head_insts;
    decoded_packet_t [`DISPATCH_WIDTH-1:0] decoded;
    disp_cnt_t                             rob_open;
    disp_cnt_t                             rs_open;
    logic                                  bs_full;
    disp_cnt_t                             bs_alloc;

    // one stack entry per branch leaving from slot 0
    assign bs_alloc = disp_cnt_t'(out_insts[0].cond_branch | out_insts[0].uncond_branch);

    inst_buffer u_ibuf (
        .clock(clock), .arst_n(arst_n), .fetch_valid(fetch_valid),
        .fetch_count(fetch_count), .fetch_pc(fetch_pc), .fetch_insts(fetch_insts),
        .num_dispatch(num_dispatch), .head_insts(head_insts), .fetch_room(fetch_room)
    );

    rv32_decode u_decode (.head_insts(head_insts), .decoded(decoded));

    dispatch u_dispatch (
        .rob_open(rob_open), .rs_open(rs_open), .bs_full(bs_full),
        .decoded(decoded), .num_dispatch(num_dispatch), .out_insts(out_insts)
    );

    slot_counter #(.DEPTH(`ROB_DEPTH)) rob_cnt (
        .clock(clock), .arst_n(arst_n), .alloc(num_dispatch),
        .free(releases.rob_free), .open(rob_open), .full()
    );

    slot_counter #(.DEPTH(`RS_DEPTH)) rs_cnt (
        .clock(clock), .arst_n(arst_n), .alloc(num_dispatch),
        .free(releases.rs_free), .open(rs_open), .full()
    );

    // branch stack, only its full flag matters
    slot_counter #(.DEPTH(`BS_DEPTH)) bs_cnt (
        .clock(clock), .arst_n(arst_n), .alloc(bs_alloc),
        .free(disp_cnt_t'(releases.bs_free)), .open(), .full(bs_full)
    );

endmodule

`default_nettype wire

// File: src/inst_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "ooo_consts.svh"

module inst_buffer (
    input  logic                                        clock,
    input  logic                                        arst_n,
    input  logic                                        fetch_valid,
    input  ooo_pkg::disp_cnt_t                          fetch_count,
    input  ooo_pkg::addr_t                              fetch_pc,
    input  ooo_pkg::inst_t       [`DISPATCH_WIDTH-1:0]  fetch_insts,
    input  ooo_pkg::disp_cnt_t                          num_dispatch,
    output ooo_pkg::inst_packet_t [`DISPATCH_WIDTH-1:0] head_insts,
    output logic                                        fetch_room
);

    import ooo_pkg::*;

    localparam int PW = $clog2(`IBUF_DEPTH);
    localparam int CW = $clog2(`IBUF_DEPTH + 1);

    // payload storage
    inst_t mem_inst [`IBUF_DEPTH];
    addr_t mem_pc   [`IBUF_DEPTH];

    logic [PW-1:0] head;
    logic [PW-1:0] tail;
    logic [CW-1:0] count;
    logic          push;
    disp_cnt_t     push_n;

    // room for a whole group
    assign fetch_room = (CW'(`IBUF_DEPTH) - count) >= CW'(`DISPATCH_WIDTH);
    // strobe without room dropped
    assign push       = fetch_valid && fetch_room;
    // clip an oversized count
    assign push_n = !push ? '0 :
                    (fetch_count > disp_cnt_t'(`DISPATCH_WIDTH)) ?
                    disp_cnt_t'(`DISPATCH_WIDTH) : fetch_count;

    // entry writes, pc of slot k is base plus 4k
    always_ff @(posedge clock) begin
        for (int k = 0; k < `DISPATCH_WIDTH; k++) begin
            if (k < push_n) begin
                mem_inst[tail + PW'(k)] <= fetch_insts[k];
                mem_pc[tail + PW'(k)]   <= fetch_pc + addr_t'(4 * k);
            end
        end
    end

    // pointers and occupancy, pop and push on one edge
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head + PW'(num_dispatch);
            tail  <= tail + PW'(push_n);
            count <= count + CW'(push_n) - CW'(num_dispatch);
        end
    end

    // head window, empty slots zeroed
    always_comb begin
        head_insts = '0;
        for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
            if (count > CW'(i)) begin
                head_insts[i].valid = 1'b1;
                head_insts[i].inst  = mem_inst[head + PW'(i)];
                head_insts[i].pc    = mem_pc[head + PW'(i)];
            end
        end
    end

endmodule

`default_nettype wire

// File: src/ooo_consts.svh
`ifndef OOO_CONSTS_SVH
`define OOO_CONSTS_SVH

// instructions per fetch group and per dispatch
`define DISPATCH_WIDTH 4
// instruction buffer entries, kept a power of two
`define IBUF_DEPTH 8
// back-end capacities
`define ROB_DEPTH 16
`define RS_DEPTH 8
`define BS_DEPTH 4

// rv32i major opcodes
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011
`define OPC_BRANCH 7'b1100011
`define OPC_JAL    7'b1101111
`define OPC_JALR   7'b1100111
`define OPC_OP_IMM 7'b0010011
`define OPC_OP     7'b0110011
`define OPC_LUI    7'b0110111
`define OPC_AUIPC  7'b0010111

`endif

// File: src/ooo_pkg.sv
`default_nettype none

`include "ooo_consts.svh"

package ooo_pkg;

    // raw instruction word and pc
    typedef logic [31:0] inst_t;
    typedef logic [31:0] addr_t;
    // architectural register index
    typedef logic [4:0] reg_idx_t;
    // sign-extended immediate
    typedef logic [31:0] imm_t;
    // 0 .. DISPATCH_WIDTH
    typedef logic [$clog2(`DISPATCH_WIDTH + 1)-1:0] disp_cnt_t;

    // functional unit class picked by decode
    typedef enum logic [1:0] {
        FU_ALU,
        FU_MEM,
        FU_BRANCH,
        FU_ILLEGAL
    } fu_class_e;

    // one buffered instruction, 65 bits
    typedef struct packed {
        logic  valid;
        inst_t inst;
        addr_t pc;
    } inst_packet_t;

    // decoder output per slot
    typedef struct packed {
        logic      valid;
        inst_t     inst;
        addr_t     pc;
        fu_class_e fu_class;
        reg_idx_t  rd;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        imm_t      imm;
        logic      cond_branch;
        logic      uncond_branch;
        logic      writes_rd;
    } decoded_packet_t;

    // slot returns from later stages
    typedef struct packed {
        disp_cnt_t rob_free;
        disp_cnt_t rs_free;
        logic      bs_free;
    } release_t;

endpackage

`default_nettype wire

// File: src/rv32_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "ooo_consts.svh"

module rv32_decode (
    input  ooo_pkg::inst_packet_t    [`DISPATCH_WIDTH-1:0] head_insts,
    output ooo_pkg::decoded_packet_t [`DISPATCH_WIDTH-1:0] decoded
);

    import ooo_pkg::*;

    // decode a single buffer entry
    function automatic decoded_packet_t decode_one(input inst_packet_t pkt);
        decoded_packet_t d;
        inst_t           i;
        logic            rd_used;
        d       = '0;
        i       = pkt.inst;
        rd_used = 1'b0;
        // empty slot stays all zero
        if (pkt.valid) begin
            d.valid    = 1'b1;
            d.inst     = i;
            d.pc       = pkt.pc;
            // register fields are raw, meaning depends on format
            d.rd       = i[11:7];
            d.rs1      = i[19:15];
            d.rs2      = i[24:20];
            d.fu_class = FU_ILLEGAL;
            case (i[6:0])
                `OPC_OP: begin
                    d.fu_class = FU_ALU;
                    rd_used    = 1'b1;
                end
                `OPC_OP_IMM, `OPC_LOAD: begin
                    // I-type
                    d.fu_class = (i[6:0] == `OPC_LOAD) ? FU_MEM : FU_ALU;
                    d.imm      = {{20{i[31]}}, i[31:20]};
                    rd_used    = 1'b1;
                end
                `OPC_STORE: begin
                    // S-type, no destination
                    d.fu_class = FU_MEM;
                    d.imm      = {{20{i[31]}}, i[31:25], i[11:7]};
                end
                `OPC_BRANCH: begin
                    // B-type, offset in halfwords
                    d.fu_class    = FU_BRANCH;
                    d.cond_branch = 1'b1;
                    d.imm = {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
                end
                `OPC_JAL: begin
                    // J-type, link in rd
                    d.fu_class      = FU_BRANCH;
                    d.uncond_branch = 1'b1;
                    d.imm = {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
                    rd_used         = 1'b1;
                end
                `OPC_JALR: begin
                    d.fu_class      = FU_BRANCH;
                    d.uncond_branch = 1'b1;
                    d.imm           = {{20{i[31]}}, i[31:20]};
                    rd_used         = 1'b1;
                end
                `OPC_LUI, `OPC_AUIPC: begin
                    // U-type, upper 20 bits
                    d.fu_class = FU_ALU;
                    d.imm      = {i[31:12], 12'b0};
                    rd_used    = 1'b1;
                end
                default: begin
                    // illegal, nothing written
                    d.fu_class = FU_ILLEGAL;
                end
            endcase
            // x0 is never a real destination
            d.writes_rd = rd_used && (i[11:7] != 5'd0);
        end
        return d;
    endfunction

    // all slots decoded in parallel
    always_comb begin
        for (int s = 0; s < `DISPATCH_WIDTH; s++) begin
            decoded[s] = decode_one(head_insts[s]);
        end
    end

endmodule

`default_nettype wire

// File: src/slot_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "ooo_consts.svh"

module slot_counter #(
    parameter int DEPTH = 16
) (
    input  logic               clock,
    input  logic               arst_n,
    input  ooo_pkg::disp_cnt_t alloc,
    input  ooo_pkg::disp_cnt_t free,
    output ooo_pkg::disp_cnt_t open,
    output logic               full
);

    import ooo_pkg::*;

    localparam int CW = $clog2(DEPTH + 1);

    logic [CW-1:0] count;
    logic [CW-1:0] space;

    // occupied entries
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else begin
            count <= count + CW'(alloc) - CW'(free);
        end
    end

    assign space = CW'(DEPTH) - count;
    // never report more than one group's worth
    assign open  = (space > CW'(`DISPATCH_WIDTH)) ? disp_cnt_t'(`DISPATCH_WIDTH) :
                   disp_cnt_t'(space);
    assign full  = (count == CW'(DEPTH));

endmodule

`default_nettype wire

// File: tb/dispatch_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ooo_consts.svh"

module dispatch_tb;

    import ooo_pkg::*;

    localparam int DW          = `DISPATCH_WIDTH;
    localparam int DRAIN_LIMIT = 100;

    // table words for each format
    localparam inst_t I_ADD      = 32'h002081B3;
    localparam inst_t I_ADDI     = 32'h00510093;
    localparam inst_t I_ADDI_NEG = 32'hFFF10093;
    localparam inst_t I_NOP      = 32'h00000013;
    localparam inst_t I_LW       = 32'h00452183;
    localparam inst_t I_SW       = 32'hFE112E23;
    localparam inst_t I_BEQ      = 32'hFE208EE3;
    localparam inst_t I_JAL      = 32'h008000EF;
    // jalr with x0 as rd
    localparam inst_t I_JALR     = 32'h00008067;
    localparam inst_t I_LUI      = 32'h123450B7;
    localparam inst_t I_AUIPC    = 32'h00001117;
    localparam inst_t I_BAD      = 32'hFFFFFFFF;

    // one table row with fetch group, releases and trailing idle cycles
    typedef struct packed {
        disp_cnt_t      count;
        addr_t          pc;
        inst_t [DW-1:0] words;
        release_t       rel;
        logic [7:0]     idle;
    } row_t;

    logic                     clock;
    logic                     arst_n;
    logic                     fetch_valid;
    disp_cnt_t                fetch_count;
    addr_t                    fetch_pc;
    inst_t [DW-1:0]           fetch_insts;
    logic                     fetch_room;
    release_t                 releases;
    disp_cnt_t                num_dispatch;
    decoded_packet_t [DW-1:0] out_insts;

    // reference model state
    inst_t           q_inst [$];
    addr_t           q_pc [$];
    int              rob_used;
    int              rs_used;
    int              bs_used;
    int              exp_num;
    decoded_packet_t exp_pkt [DW];
    row_t            table_q [$];
    int              errors;
    int              checks;
    // strobes the DUT refused
    int              dropped;
    logic            timed_out;

    initial begin
        clock = 1'b0;
        forever begin
            #4 clock = ~clock;
        end
    end

    dispatch_top dut0 (
        .clock(clock), .arst_n(arst_n), .fetch_valid(fetch_valid),
        .fetch_count(fetch_count), .fetch_pc(fetch_pc), .fetch_insts(fetch_insts),
        .fetch_room(fetch_room), .releases(releases), .num_dispatch(num_dispatch),
        .out_insts(out_insts)
    );

    task automatic check_value(input logic [127:0] got, input logic [127:0] exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // sign extend the low bits of v
    function automatic imm_t sext(input logic [31:0] v, input int bits);
        logic signed [31:0] t;
        t = $signed(v << (32 - bits));
        return imm_t'(t >>> (32 - bits));
    endfunction

    function automatic int min_int(input int a, input int b);
        return (a < b) ? a : b;
    endfunction

    // expected decoder output for one entry
    function automatic decoded_packet_t model_decode(input inst_t w, input addr_t pc);
        decoded_packet_t d;
        logic            dest;
        d          = '0;
        dest       = 1'b0;
        d.valid    = 1'b1;
        d.inst     = w;
        d.pc       = pc;
        d.rd       = w[11:7];
        d.rs1      = w[19:15];
        d.rs2      = w[24:20];
        case (w[6:0])
            `OPC_OP: begin
                d.fu_class = FU_ALU;
                dest       = 1'b1;
            end
            `OPC_OP_IMM: begin
                d.fu_class = FU_ALU;
                d.imm      = sext(32'(w[31:20]), 12);
                dest       = 1'b1;
            end
            `OPC_LOAD: begin
                d.fu_class = FU_MEM;
                d.imm      = sext(32'(w[31:20]), 12);
                dest       = 1'b1;
            end
            `OPC_LUI, `OPC_AUIPC: begin
                d.fu_class = FU_ALU;
                d.imm      = {w[31:12], 12'h000};
                dest       = 1'b1;
            end
            `OPC_STORE: begin
                d.fu_class = FU_MEM;
                d.imm      = sext(32'({w[31:25], w[11:7]}), 12);
            end
            `OPC_BRANCH: begin
                d.fu_class    = FU_BRANCH;
                d.cond_branch = 1'b1;
                d.imm = sext(32'({w[31], w[7], w[30:25], w[11:8], 1'b0}), 13);
            end
            `OPC_JAL, `OPC_JALR: begin
                d.fu_class      = FU_BRANCH;
                d.uncond_branch = 1'b1;
                dest            = 1'b1;
                if (w[6:0] == `OPC_JAL) begin
                    d.imm = sext(32'({w[31], w[19:12], w[20], w[30:21], 1'b0}), 21);
                end else begin
                    d.imm = sext(32'(w[31:20]), 12);
                end
            end
            default: begin
                d.fu_class = FU_ILLEGAL;
            end
        endcase
        // x0 as destination writes nothing
        d.writes_rd = dest && (d.rd != 5'd0);
        return d;
    endfunction

    // expected dispatch for the current model state
    task automatic predict;
        int              lim;
        logic            stop;
        decoded_packet_t d;
        lim = min_int(min_int(q_inst.size(), DW), min_int(`ROB_DEPTH - rob_used, DW));
        lim = min_int(lim, min_int(`RS_DEPTH - rs_used, DW));
        exp_num = 0;
        stop    = 1'b0;
        for (int i = 0; i < DW; i++) begin
            exp_pkt[i] = '0;
            if (stop || i >= lim) begin
                stop = 1'b1;
            end else begin
                d = model_decode(q_inst[i], q_pc[i]);
                // branches only lead a group and need a stack entry
                if ((d.cond_branch || d.uncond_branch) && (i != 0 || bs_used >= `BS_DEPTH)) begin
                    stop = 1'b1;
                end else begin
                    exp_pkt[i] = d;
                    exp_num++;
                end
            end
        end
    endtask

    // state after the next edge
    task automatic advance_model(input logic strobe, input row_t row, input release_t rel);
        logic room;
        logic br0;
        room = (`IBUF_DEPTH - q_inst.size()) >= DW;
        br0  = (exp_num > 0) && (exp_pkt[0].cond_branch || exp_pkt[0].uncond_branch);
        repeat (exp_num) begin
            void'(q_inst.pop_front());
            void'(q_pc.pop_front());
        end
        rob_used = rob_used + exp_num - int'(rel.rob_free);
        rs_used  = rs_used + exp_num - int'(rel.rs_free);
        bs_used  = bs_used + int'(br0) - int'(rel.bs_free);
        // accepted group lands behind the remaining entries
        if (strobe && room) begin
            for (int k = 0; k < int'(row.count); k++) begin
                q_inst.push_back(row.words[k]);
                q_pc.push_back(row.pc + addr_t'(4 * k));
            end
        end
    endtask

    // never return more than is held
    function automatic release_t clip_release(input int rob, input int rs, input int bs);
        release_t r;
        r.rob_free = disp_cnt_t'(min_int(rob, rob_used));
        r.rs_free  = disp_cnt_t'(min_int(rs, rs_used));
        r.bs_free  = (bs != 0) && (bs_used != 0);
        return r;
    endfunction

    // drive on the rising edge and check at the falling edge
    task automatic run_cycle(input logic strobe, input row_t row, input release_t rel);
        @(posedge clock);
        fetch_valid <= strobe;
        fetch_count <= strobe ? row.count : '0;
        fetch_pc    <= row.pc;
        fetch_insts <= row.words;
        releases    <= rel;
        @(negedge clock);
        predict();
        check_value(128'(num_dispatch), 128'(exp_num), "num_dispatch");
        check_value(128'(fetch_room), 128'(q_inst.size() <= `IBUF_DEPTH - DW), "fetch_room");
        for (int i = 0; i < DW; i++) begin
            check_value(128'(out_insts[i]), 128'(exp_pkt[i]), $sformatf("out_insts[%0d]", i));
        end
        // strobe meets a low fetch_room so the next edge drops it
        if (strobe && !fetch_room) begin
            dropped++;
        end
        advance_model(strobe, row, rel);
    endtask

    task automatic add_row(input int cnt, input addr_t pc, input inst_t w0, input inst_t w1,
                           input inst_t w2, input inst_t w3, input int rob, input int rs,
                           input int bs, input int idle);
        row_t r;
        r.count        = disp_cnt_t'(cnt);
        r.pc           = pc;
        r.words        = {w3, w2, w1, w0};
        r.rel.rob_free = disp_cnt_t'(rob);
        r.rel.rs_free  = disp_cnt_t'(rs);
        r.rel.bs_free  = (bs != 0);
        r.idle         = 8'(idle);
        table_q.push_back(r);
    endtask

    task automatic build_table;
        // alu groups until the rs fills and then releases
        add_row(4, 32'h1000, I_ADD, I_ADDI, I_LUI, I_AUIPC, 0, 0, 0, 2);
        add_row(4, 32'h1010, I_ADDI, I_ADD, I_ADD, I_ADDI, 0, 0, 0, 2);
        add_row(4, 32'h1020, I_ADD, I_ADDI_NEG, I_ADD, I_LUI, 0, 0, 0, 3);
        add_row(0, 32'h0, I_NOP, I_NOP, I_NOP, I_NOP, 4, 4, 0, 2);
        add_row(0, 32'h0, I_NOP, I_NOP, I_NOP, I_NOP, 4, 4, 0, 2);
        // branch at slot 0 and then mid-group branches
        add_row(4, 32'h2000, I_BEQ, I_ADD, I_ADDI, I_LW, 4, 4, 0, 2);
        add_row(4, 32'h2010, I_ADD, I_ADDI, I_JAL, I_SW, 4, 4, 0, 3);
        add_row(4, 32'h2020, I_JALR, I_ADD, I_BEQ, I_LUI, 4, 4, 0, 3);
        // stack now full so the head branch waits for bs_free
        add_row(2, 32'h2030, I_BEQ, I_ADD, I_NOP, I_NOP, 4, 4, 0, 3);
        add_row(0, 32'h0, I_NOP, I_NOP, I_NOP, I_NOP, 4, 4, 1, 2);
        // remaining formats
        add_row(4, 32'h3000, I_SW, I_LW, I_ADDI_NEG, I_NOP, 4, 4, 1, 2);
        add_row(4, 32'h3010, I_BAD, I_JALR, I_AUIPC, I_JAL, 4, 4, 1, 3);
        // back to back groups with no release fill the buffer
        add_row(4, 32'h4000, I_ADD, I_ADD, I_ADD, I_ADD, 0, 0, 0, 0);
        add_row(4, 32'h4010, I_ADDI, I_ADDI, I_ADDI, I_ADDI, 0, 0, 0, 0);
        add_row(4, 32'h4020, I_LUI, I_LUI, I_LUI, I_LUI, 0, 0, 0, 0);
        add_row(4, 32'h4030, I_ADD, I_ADD, I_ADD, I_ADD, 0, 0, 0, 0);
        add_row(4, 32'h4040, I_ADDI, I_ADDI, I_ADDI, I_ADDI, 0, 0, 0, 2);
    endtask

    initial begin
        row_t idle_row;
        int   errs_before;
        int   cycles;
        arst_n      = 1'b0;
        fetch_valid = 1'b0;
        fetch_count = '0;
        fetch_pc    = '0;
        fetch_insts = '0;
        releases    = '0;
        rob_used    = 0;
        rs_used     = 0;
        bs_used     = 0;
        errors      = 0;
        checks      = 0;
        dropped     = 0;
        timed_out   = 1'b0;
        idle_row    = '0;
        build_table();
        repeat (5) @(posedge clock);
        arst_n <= 1'b1;

        // idle outputs out of reset
        errs_before = errors;
        run_cycle(1'b0, idle_row, '0);
        check_value(128'(num_dispatch), 128'(0), "num_dispatch after reset");
        check_value(128'(fetch_room), 128'(1), "fetch_room after reset");
        for (int i = 0; i < DW; i++) begin
            check_value(128'(out_insts[i]), 128'(0), $sformatf("out_insts[%0d] after reset", i));
        end
        $display("reset: %0d mismatches", errors - errs_before);

        for (int r = 0; r < table_q.size(); r++) begin
            errs_before = errors;
            run_cycle(table_q[r].count != 0, table_q[r],
                      clip_release(int'(table_q[r].rel.rob_free),
                                   int'(table_q[r].rel.rs_free),
                                   int'(table_q[r].rel.bs_free)));
            for (int c = 0; c < int'(table_q[r].idle); c++) begin
                run_cycle(1'b0, idle_row, '0);
            end
            $display("row %0d: %0d insts at %h, %0d idle, %0d mismatches", r,
                     table_q[r].count, table_q[r].pc, table_q[r].idle, errors - errs_before);
        end

        // release everything until buffer and counters are empty
        errs_before = errors;
        cycles      = 0;
        while ((q_inst.size() != 0 || rob_used != 0 || rs_used != 0 || bs_used != 0)
               && cycles < DRAIN_LIMIT) begin
            run_cycle(1'b0, idle_row, clip_release(DW, DW, 1));
            cycles++;
        end
        if (cycles >= DRAIN_LIMIT) begin
            timed_out = 1'b1;
            $display("timeout: buffer and counters still busy after %0d cycles", cycles);
        end
        $display("drain: %0d cycles, %0d mismatches", cycles, errors - errs_before);

        if (dropped == 0) begin
            errors++;
            $display("the DUT never lowered fetch_room while a fetch strobe was sent");
        end
        $display("summary: %0d checks, %0d mismatches, %0d dropped strobes",
                 checks, errors, dropped);
        if (errors == 0 && !timed_out) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+src
src/ooo_pkg.sv
src/rv32_decode.sv
src/dispatch.sv
src/inst_buffer.sv
src/slot_counter.sv
src/dispatch_top.sv
tb/dispatch_tb.sv
